//--- sim.f
verilog/isaPkg.sv
verilog/cpuCtrlPkg.sv
verilog/controlUnit.sv
verilog/registerFile.sv
verilog/alu.sv
verilog/memoryIo.sv
verilog/cpu.sv
test/memoryModel.sv
test/cpuTb.sv

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -f sim.f --top-module cpuTb -o cpuTbSim
./obj_dir/cpuTbSim > sim.log 2>&1 || true
cat sim.log

if grep -q "=== FAIL ===" sim.log; then
	exit 1
fi
if ! grep -q "=== PASS ===" sim.log; then
	exit 1
fi
exit 0

//--- test/cpuTb.sv
`timescale 1ns/1ps

module cpuTb;

	typedef struct packed {
		logic [15:0] addr;
		logic [15:0] data;
	} storeEntry_t;

	localparam int programLen = 50;
	localparam int storeCount = 18;
	localparam int waitLimit = 400;

	logic clk;
	logic reset_n;
	logic readM;
	logic writeM;
	logic [15:0] address;
	wire [15:0] data;
	logic inputReady;
	logic ackOutput;
	int errors;
	int cycles;
	bit timedOut;

	// Words 0 to 49, see the expected stores below.
	logic [15:0] programWords [programLen] = '{
		16'h6012, 16'h5034, 16'h6100, 16'h550F, 16'hF180, 16'h8E60, // Load values, ADD.
		16'hF181, 16'h8E61, 16'hF182, 16'h8E62, 16'hF183, 16'h8E63,
		16'hF184, 16'h8E64, 16'hF185, 16'h8E65, 16'hF186, 16'h8E66,
		16'hF187, 16'h8E67,
		16'h46FD, 16'h8E68, 16'h5E80, 16'h8E69, 16'h4E80, 16'h8E6A, // Extension.
		16'h7E7F, 16'h8E6B, // Load then store.
		16'h1001, 16'h8C6C, 16'h1101, 16'h8C6D, // BEQ taken, not taken.
		16'h0101, 16'h8C6E, 16'h0001, 16'h8C6F, // BNE.
		16'h2001, 16'h8C70, 16'h2801, 16'h8C71, // BGZ.
		16'h3801, 16'h8C72, 16'h3001, 16'h8C73, // BLZ.
		16'hA030, 16'h8D75, 16'h902E, 16'h902F, // JAL, return path, final loop.
		16'h8E74, 16'hF819 // Store link, JPR.
	};

	storeEntry_t expected [storeCount] = '{
		{16'h0060, 16'h1243}, {16'h0061, 16'h1225}, {16'h0062, 16'h0004},
		{16'h0063, 16'h123F}, {16'h0064, 16'hEDCB}, {16'h0065, 16'hEDCC},
		{16'h0066, 16'h2468}, {16'h0067, 16'h091A}, {16'h0068, 16'h000C},
		{16'h0069, 16'h0080}, {16'h006A, 16'hFF80}, {16'h006B, 16'hBEEF},
		{16'h006D, 16'h1234}, {16'h006F, 16'h1234}, {16'h0071, 16'h1234},
		{16'h0073, 16'h1234}, {16'h0074, 16'h002D}, {16'h0075, 16'h000F}
	};

	cpu #(.dataWidth(16)) DUT (
		.clk(clk),
		.reset_n(reset_n),
		.readM(readM),
		.writeM(writeM),
		.address(address),
		.data(data),
		.inputReady(inputReady),
		.ackOutput(ackOutput)
	);

	memoryModel #(.dataWidth(16), .maxDelay(3)) memory (
		.clk(clk),
		.readM(readM),
		.writeM(writeM),
		.address(address),
		.data(data),
		.inputReady(inputReady),
		.ackOutput(ackOutput)
	);

	always #2 clk = ~clk;

	// A read and a write never overlap on the bus.
	always @(posedge clk) begin
		if (!reset_n && readM && writeM) begin
			$display("readM and writeM high together at %0t", $time);
			errors++;
		end
	end

	initial begin
		clk = 1'b0;
		reset_n = 1'b1;
		errors = 0;
		timedOut = 1'b0;
		for (int a = 0; a < 65536; a++) begin
			memory.mem[a] = 16'(a) ^ 16'h5A5A ^ {16'(a) << 7}; // Whole-address pattern.
		end
		for (int i = 0; i < programLen; i++) begin
			memory.mem[i] = programWords[i];
		end
		memory.mem[16'h007F] = 16'hBEEF;
		repeat (10) @(posedge clk);
		@(negedge clk);
		reset_n = 1'b0;

		for (int i = 0; i < storeCount && !timedOut; i++) begin
			cycles = 0;
			@(posedge clk);
			while (!(writeM && ackOutput) && cycles < waitLimit) begin
				cycles++;
				@(posedge clk);
			end
			if (!(writeM && ackOutput)) begin
				$display("Timed out waiting for store %0d of %0d", i, storeCount);
				errors++;
				timedOut = 1'b1;
			end else begin
				if (address !== expected[i].addr) begin
					$display("[FAIL] %0t address exp %h got %h", $time, expected[i].addr,
						address);
					errors++;
				end
				if (data !== expected[i].data) begin
					$display("[FAIL] %0t data exp %h got %h", $time, expected[i].data, data);
					errors++;
				end
			end
		end

		// The program now loops on itself with no more writes.
		if (!timedOut) begin
			repeat (200) begin
				@(posedge clk);
				if (writeM) begin
					$display("Extra write to address %h after the last store", address);
					errors++;
				end
			end
		end

		$display("Stores checked: %0d, errors: %0d", storeCount, errors);
		if (errors == 0) begin
			$display("=== PASS ===");
		end else begin
			$display("=== FAIL ===");
		end
		$finish;
	end

endmodule

//--- test/memoryModel.sv
`timescale 1ns/1ps

module memoryModel #(
	parameter int dataWidth = 16,
	parameter int maxDelay = 3
) (
	input logic clk,
	input logic readM,
	input logic writeM,
	input logic [dataWidth-1:0] address,
	inout wire [dataWidth-1:0] data,
	output logic inputReady,
	output logic ackOutput
);

	logic [dataWidth-1:0] mem [1 << dataWidth]; // Filled by the testbench.
	logic [31:0] rngState;
	logic busy;
	int waitCount;

	function automatic logic [31:0] xorshift(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	initial begin
		rngState = 32'h41ca;
		busy = 1'b0;
		waitCount = 0;
		inputReady = 1'b0;
		ackOutput = 1'b0;
	end

	// Ready signals change on the falling edge only.
	always @(negedge clk) begin
		inputReady <= 1'b0;
		ackOutput <= 1'b0;
		if (readM || writeM) begin
			if (!busy) begin
				rngState = xorshift(rngState);
				waitCount = int'(rngState % (maxDelay + 1));
				busy = 1'b1;
			end
			if (waitCount == 0) begin
				inputReady <= readM;
				ackOutput <= writeM;
				busy = 1'b0;
			end else begin
				waitCount = waitCount - 1;
			end
		end
	end

	always @(posedge clk) begin
		if (writeM && ackOutput) mem[address] <= data;
	end

	assign data = readM ? mem[address] : {dataWidth{1'bz}}; // Only while reading.

endmodule

//--- verilog/cpu.sv
`timescale 1ns/1ps

module cpu
	import isaPkg::*;
	import cpuCtrlPkg::*;
#(
	parameter int dataWidth = wordSize
) (
	input logic clk,
	input logic reset_n,
	output logic readM,
	output logic writeM,
	output logic [dataWidth-1:0] address,
	inout wire [dataWidth-1:0] data,
	input logic inputReady,
	input logic ackOutput
);

	logic [dataWidth-1:0] pc;
	logic [dataWidth-1:0] pcPlusOne;
	logic [dataWidth-1:0] nextPc;
	logic running;
	logic startInstr;
	logic instrDone;
	logic [dataWidth-1:0] instruction;
	ctrlSignals_t ctrl;
	opcode_e opcode;
	logic [regAddrWidth-1:0] rs;
	logic [regAddrWidth-1:0] rt;
	logic [regAddrWidth-1:0] rd;
	logic [regAddrWidth-1:0] writeAddr;
	logic [immWidth-1:0] imm;
	logic [dataWidth-1:0] signImm;
	logic [dataWidth-1:0] immExt;
	logic [dataWidth-1:0] operandB;
	logic [dataWidth-1:0] aluResult;
	logic branchTaken;
	logic [dataWidth-1:0] readData1;
	logic [dataWidth-1:0] readData2;
	logic [dataWidth-1:0] loadData;
	logic [dataWidth-1:0] writeData;

	assign opcode = opcode_e'(instruction[opcodeLsb +: opcodeWidth]);
	assign rs = instruction[rsLsb +: regAddrWidth];
	assign rt = instruction[rtLsb +: regAddrWidth];
	assign rd = instruction[rdLsb +: regAddrWidth];
	assign imm = instruction[immLsb +: immWidth];

	assign signImm = {{(dataWidth-immWidth){imm[immWidth-1]}}, imm};
	assign immExt = ctrl.zeroExtend ? {{(dataWidth-immWidth){1'b0}}, imm} : signImm; // ORI only.
	assign operandB = ctrl.aluSrcImm ? immExt : readData2;
	assign pcPlusOne = pc + 1'b1;
	assign writeData = ctrl.pcToReg ? pcPlusOne : (ctrl.memToReg ? loadData : aluResult);

	always_comb begin
		case (ctrl.destSel)
			destRd: writeAddr = rd;
			destLink: writeAddr = regAddrWidth'(linkReg);
			default: writeAddr = rt;
		endcase
	end

	always_comb begin
		if (ctrl.jump) nextPc = {pc[dataWidth-1:targetWidth], instruction[targetLsb +: targetWidth]};
		else if (ctrl.jumpReg) nextPc = readData1;
		else if (ctrl.branch && branchTaken) nextPc = pcPlusOne + signImm;
		else nextPc = pcPlusOne;
	end

	always_ff @(posedge clk) begin
		if (reset_n) begin
			pc <= '0;
			running <= 1'b0;
			startInstr <= 1'b0;
		end else begin
			running <= 1'b1;
			startInstr <= !running || instrDone; // First start right after reset.
			if (instrDone) pc <= nextPc;
		end
	end

	controlUnit #(.dataWidth(dataWidth)) uControl (
		.instr(instruction),
		.ctrl(ctrl)
	);

	registerFile #(.dataWidth(dataWidth), .regCount(1 << regAddrWidth)) uRegs (
		.clk(clk),
		.reset_n(reset_n),
		.readAddr1(rs),
		.readAddr2(rt),
		.writeAddr(writeAddr),
		.writeData(writeData),
		.writeEnable(ctrl.regWrite && instrDone),
		.readData1(readData1),
		.readData2(readData2)
	);

	alu #(.dataWidth(dataWidth)) uAlu (
		.operandA(readData1),
		.operandB(operandB),
		.aluOp(ctrl.aluOp),
		.opcode(opcode),
		.result(aluResult),
		.branchTaken(branchTaken)
	);

	memoryIo #(.dataWidth(dataWidth)) uMemIo (
		.clk(clk),
		.reset_n(reset_n),
		.startInstr(startInstr),
		.pc(pc),
		.ctrl(ctrl),
		.dataAddr(aluResult),
		.storeData(readData2),
		.inputReady(inputReady),
		.ackOutput(ackOutput),
		.readM(readM),
		.writeM(writeM),
		.address(address),
		.data(data),
		.instruction(instruction),
		.loadData(loadData),
		.instrDone(instrDone)
	);

endmodule

//--- verilog/memoryIo.sv
`timescale 1ns/1ps

module memoryIo
	import isaPkg::*;
	import cpuCtrlPkg::*;
#(
	parameter int dataWidth = wordSize
) (
	input logic clk,
	input logic reset_n,
	input logic startInstr,
	input logic [dataWidth-1:0] pc,
	input ctrlSignals_t ctrl,
	input logic [dataWidth-1:0] dataAddr,
	input logic [dataWidth-1:0] storeData,
	input logic inputReady,
	input logic ackOutput,
	output logic readM,
	output logic writeM,
	output logic [dataWidth-1:0] address,
	inout wire [dataWidth-1:0] data,
	output logic [dataWidth-1:0] instruction,
	output logic [dataWidth-1:0] loadData,
	output logic instrDone
);

	busState_e state;
	busState_e nextState;
	logic fetched; // Word latched, decode valid this cycle.
	logic driveBus;

	always_comb begin
		nextState = state;
		case (state)
			busIdle: if (startInstr) nextState = busFetch;
			busFetch: begin
				if (fetched) begin
					if (ctrl.memRead) nextState = busLoad;
					else if (ctrl.memWrite) nextState = busStore;
					else nextState = busDone;
				end
			end
			busLoad: if (inputReady) nextState = busDone;
			busStore: if (ackOutput) nextState = busDone;
			busDone: nextState = busIdle;
			default: nextState = busIdle;
		endcase
	end

	always_ff @(posedge clk) begin
		if (reset_n) begin
			state <= busIdle;
			fetched <= 1'b0;
		end else begin
			state <= nextState;
			fetched <= (state == busFetch) && !fetched && inputReady;
		end
	end

	always_ff @(posedge clk) begin
		if (readM && inputReady) begin
			if (state == busFetch) instruction <= data;
			else loadData <= data;
		end
	end

	assign readM = (state == busFetch && !fetched) || state == busLoad;
	assign driveBus = state == busStore;
	assign writeM = driveBus;
	assign data = driveBus ? storeData : {dataWidth{1'bz}};
	assign address = (state == busLoad || state == busStore) ? dataAddr : pc;
	assign instrDone = state == busDone;

	assert property (@(posedge clk) disable iff (reset_n) !(readM && writeM))
		else $error("readM and writeM high together");
	assert property (@(posedge clk) disable iff (reset_n) readM |-> !driveBus)
		else $error("data bus driven during a read");
	assert property (@(posedge clk) disable iff (reset_n)
		readM && !inputReady |=> readM && $stable(address))
		else $error("read request dropped before inputReady");

endmodule

//--- verilog/alu.sv
`timescale 1ns/1ps

module alu
	import isaPkg::*;
	import cpuCtrlPkg::*;
#(
	parameter int dataWidth = wordSize
) (
	input logic [dataWidth-1:0] operandA,
	input logic [dataWidth-1:0] operandB,
	input aluOp_e aluOp,
	input opcode_e opcode,
	output logic [dataWidth-1:0] result,
	output logic branchTaken
);

	localparam int halfWidth = dataWidth / 2;

	always_comb begin
		case (aluOp)
			aluAdd: result = operandA + operandB;
			aluSub: result = operandA - operandB;
			aluAnd: result = operandA & operandB;
			aluOr: result = operandA | operandB;
			aluNot: result = ~operandA;
			aluTcp: result = ~operandA + 1'b1;
			aluShl: result = operandA << 1;
			aluShr: result = {operandA[dataWidth-1], operandA[dataWidth-1:1]}; // Arithmetic.
			aluLhi: result = {operandB[halfWidth-1:0], {halfWidth{1'b0}}};
			aluPassB: result = operandB;
			default: result = operandB;
		endcase
	end

	// Branches compare rs against rt.
	always_comb begin
		case (opcode)
			BNE: branchTaken = operandA != operandB;
			BEQ: branchTaken = operandA == operandB;
			BGZ: branchTaken = $signed(operandA) > 0;
			BLZ: branchTaken = $signed(operandA) < 0;
			default: branchTaken = 1'b0;
		endcase
	end

endmodule

//--- verilog/registerFile.sv
`timescale 1ns/1ps

module registerFile
	import isaPkg::*;
#(
	parameter int dataWidth = wordSize,
	parameter int regCount = 1 << regAddrWidth
) (
	input logic clk,
	input logic reset_n,
	input logic [$clog2(regCount)-1:0] readAddr1,
	input logic [$clog2(regCount)-1:0] readAddr2,
	input logic [$clog2(regCount)-1:0] writeAddr,
	input logic [dataWidth-1:0] writeData,
	input logic writeEnable,
	output logic [dataWidth-1:0] readData1,
	output logic [dataWidth-1:0] readData2
);

	logic [dataWidth-1:0] regs [regCount];

	always_ff @(posedge clk) begin
		if (reset_n) begin
			for (int i = 0; i < regCount; i++) begin
				regs[i] <= '0;
			end
		end else if (writeEnable) begin
			regs[writeAddr] <= writeData;
		end
	end

	assign readData1 = regs[readAddr1]; // Combinational read.
	assign readData2 = regs[readAddr2];

endmodule

//--- verilog/controlUnit.sv
`timescale 1ns/1ps

module controlUnit
	import isaPkg::*;
	import cpuCtrlPkg::*;
#(
	parameter int dataWidth = wordSize
) (
	input logic [dataWidth-1:0] instr,
	output ctrlSignals_t ctrl
);

	opcode_e opcode;
	funcCode_e func;

	assign opcode = opcode_e'(instr[opcodeLsb +: opcodeWidth]);
	assign func = funcCode_e'(instr[funcLsb +: funcWidth]);

	always_comb begin
		ctrl = '0;
		ctrl.aluOp = aluPassB;
		ctrl.destSel = destRt;
		case (opcode)
			ADI: begin
				ctrl.aluOp = aluAdd;
				ctrl.aluSrcImm = 1'b1;
				ctrl.regWrite = 1'b1;
			end
			ORI: begin
				ctrl.aluOp = aluOr;
				ctrl.aluSrcImm = 1'b1;
				ctrl.zeroExtend = 1'b1;
				ctrl.regWrite = 1'b1;
			end
			LHI: begin
				ctrl.aluOp = aluLhi;
				ctrl.aluSrcImm = 1'b1;
				ctrl.regWrite = 1'b1;
			end
			LWD: begin
				ctrl.aluOp = aluAdd; // Address is rs plus offset.
				ctrl.aluSrcImm = 1'b1;
				ctrl.regWrite = 1'b1;
				ctrl.memRead = 1'b1;
				ctrl.memToReg = 1'b1;
			end
			SWD: begin
				ctrl.aluOp = aluAdd;
				ctrl.aluSrcImm = 1'b1;
				ctrl.memWrite = 1'b1;
			end
			BNE, BEQ, BGZ, BLZ: begin
				ctrl.aluOp = aluSub;
				ctrl.branch = 1'b1;
			end
			JMP: ctrl.jump = 1'b1;
			JAL: begin
				ctrl.jump = 1'b1;
				ctrl.regWrite = 1'b1;
				ctrl.destSel = destLink;
				ctrl.pcToReg = 1'b1;
			end
			RTYPE: begin
				case (func)
					ADD: ctrl.aluOp = aluAdd;
					SUB: ctrl.aluOp = aluSub;
					AND: ctrl.aluOp = aluAnd;
					ORR: ctrl.aluOp = aluOr;
					NOT: ctrl.aluOp = aluNot;
					TCP: ctrl.aluOp = aluTcp;
					SHL: ctrl.aluOp = aluShl;
					SHR: ctrl.aluOp = aluShr;
					JPR: ctrl.jumpReg = 1'b1;
					JRL: begin
						ctrl.jumpReg = 1'b1;
						ctrl.regWrite = 1'b1;
						ctrl.destSel = destLink;
						ctrl.pcToReg = 1'b1;
					end
					default: ctrl.aluOp = aluPassB; // Unknown function, no write.
				endcase
				if (func inside {ADD, SUB, AND, ORR, NOT, TCP, SHL, SHR}) begin
					ctrl.regWrite = 1'b1;
					ctrl.destSel = destRd;
				end
			end
			default: ctrl.aluOp = aluPassB;
		endcase
	end

	always_comb begin
		assert (!(ctrl.memRead && ctrl.memWrite))
			else $error("decode sets memRead and memWrite together");
	end

endmodule

//--- verilog/cpuCtrlPkg.sv
package cpuCtrlPkg;

	typedef enum logic [3:0] {
		aluAdd,
		aluSub,
		aluAnd,
		aluOr,
		aluNot,
		aluTcp,
		aluShl,
		aluShr,
		aluLhi,
		aluPassB
	} aluOp_e;

	typedef enum logic [2:0] {
		busIdle,
		busFetch,
		busLoad,
		busStore,
		busDone
	} busState_e;

	typedef enum logic [1:0] {
		destRt,
		destRd,
		destLink
	} destSel_e;

	typedef struct packed {
		aluOp_e aluOp;
		logic aluSrcImm; // Operand B from the immediate.
		logic zeroExtend;
		logic regWrite;
		destSel_e destSel;
		logic memRead;
		logic memWrite;
		logic memToReg;
		logic pcToReg; // Write back PC plus 1.
		logic jump;
		logic jumpReg;
		logic branch;
	} ctrlSignals_t;

endpackage

//--- verilog/isaPkg.sv
package isaPkg;

	localparam int wordSize = 16; // Data and address width.

	localparam int opcodeWidth = 4;
	localparam int funcWidth = 6;
	localparam int regAddrWidth = 2;
	localparam int immWidth = 8;
	localparam int targetWidth = 12;

	// Low bit of each instruction field.
	localparam int opcodeLsb = 12;
	localparam int rsLsb = 10;
	localparam int rtLsb = 8;
	localparam int rdLsb = 6;
	localparam int funcLsb = 0;
	localparam int immLsb = 0;
	localparam int targetLsb = 0;

	localparam int linkReg = 2; // Return address for JAL and JRL.

	typedef enum logic [opcodeWidth-1:0] {
		BNE = 4'd0,
		BEQ = 4'd1,
		BGZ = 4'd2,
		BLZ = 4'd3,
		ADI = 4'd4,
		ORI = 4'd5,
		LHI = 4'd6,
		LWD = 4'd7,
		SWD = 4'd8,
		JMP = 4'd9,
		JAL = 4'd10,
		RTYPE = 4'd15
	} opcode_e;

	typedef enum logic [funcWidth-1:0] {
		ADD = 6'd0,
		SUB = 6'd1,
		AND = 6'd2,
		ORR = 6'd3,
		NOT = 6'd4,
		TCP = 6'd5,
		SHL = 6'd6,
		SHR = 6'd7,
		JPR = 6'd25,
		JRL = 6'd26
	} funcCode_e;

endpackage
